// ==== hdl/life_settings.svh ====
/* Life engine settings
   Board geometry and generation counter width */
`ifndef LIFE_SETTINGS_SVH
`define LIFE_SETTINGS_SVH

//////////////////////////////////////////////////
// Board geometry
//////////////////////////////////////////////////

// Cells per row, bit 0 is the leftmost cell
`define LIFE_WIDTH 16

// Rows on the board, must stay a power of two for the vertical wrap
`define LIFE_ROWS 16

//////////////////////////////////////////////////
// Counters
//////////////////////////////////////////////////

`define LIFE_GEN_BITS 32 // Total generations counter

`endif

// ==== hdl/life_pkg.sv ====
/* Life engine types
   Row, address and pipeline payload structs shared by all stages */
package life_pkg;

`include "life_settings.svh"

	typedef logic [`LIFE_WIDTH-1:0] row_t; // One row of cells, bit 0 leftmost
	typedef logic [$clog2(`LIFE_ROWS)-1:0] row_addr_t; // Row index, wraps naturally
	typedef logic [`LIFE_GEN_BITS-1:0] gen_cnt_t; // Generation count

	// Row store operations
	typedef enum logic [1:0] {
		op_none,
		op_gen_read,  // Generation stream read
		op_host_read, // Host read, returns on read_cells
		op_load       // Host write into the active bank
	} seq_op_t;

	// Sequencer to row store
	typedef struct packed {
		seq_op_t   op;
		row_addr_t addr;    // Read or load row
		row_t      cells;   // Load data
		logic      emit;    // Window full, result due
		row_addr_t wb_addr; // Row the emitted result belongs to
		logic      last;    // Final read of the generation
	} seq_cmd_t;

	// Row store to window
	typedef struct packed {
		logic      valid;
		row_t      cells;
		logic      emit;
		row_addr_t wb_addr;
		logic      last;
	} fetch_t;

	// Window to rule stage
	typedef struct packed {
		logic      valid;
		row_t      above;
		row_t      centre;
		row_t      below;
		row_addr_t wb_addr;
		logic      last;
	} triple_t;

	// Rule stage back to row store
	typedef struct packed {
		logic      valid;
		row_addr_t addr;
		row_t      cells;
		logic      last;
	} wb_t;

	localparam int pipe_depth = 3; // Read command to writeback, in cycles

endpackage

// ==== hdl/gen_sequencer.sv ====
/* Generation sequencer
   Idle and generation control, pending host requests, row command stream */
`timescale 1ns/100ps

`include "life_settings.svh"

module gen_sequencer (
	input  logic                 clk4,
	input  logic                 reset,
	input  logic                 step,       // One generation
	input  logic                 run,        // Back to back generations
	input  logic                 load,
	input  life_pkg::row_addr_t  load_row,
	input  life_pkg::row_t       load_cells,
	input  logic                 read_req,
	input  life_pkg::row_addr_t  read_row,
	input  logic                 flip_done,  // Last writeback done
	output life_pkg::seq_cmd_t   cmd,
	output logic                 busy,
	output logic                 gen_done,
	output life_pkg::gen_cnt_t   gen_count
);

	// Reads plus pipeline drain make up one generation
	localparam int gen_cycles = `LIFE_ROWS + 2 + life_pkg::pipe_depth;
	localparam int cnt_bits = $clog2(gen_cycles);

	typedef logic [cnt_bits-1:0] cnt_t;

	localparam cnt_t last_read = cnt_t'(`LIFE_ROWS + 1); // Wraps back to row 0
	localparam cnt_t last_cnt = cnt_t'(gen_cycles - 1);  // flip_done due here

	typedef enum logic {
		st_idle,
		st_gen
	} state_t;

	state_t state;
	cnt_t   cnt; // Position within the generation

	// Pending requests, serviced only when idle
	logic step_pend;
	logic load_pend;
	logic read_pend;
	life_pkg::row_addr_t pend_load_row;
	life_pkg::row_t      pend_load_cells;
	life_pkg::row_addr_t pend_read_row;

	logic idle;
	logic issue_load;
	logic issue_read;
	logic start;

	assign idle = (state == st_idle);
	assign issue_load = idle && load_pend;               // Loads first
	assign issue_read = idle && !load_pend && read_pend;
	assign start = idle && !load_pend && !read_pend && (step || step_pend || run);
	assign busy = !idle;

	//////////////////////////////////////////////////
	// Control state
	//////////////////////////////////////////////////

	always_ff @(posedge clk4) begin
		if (reset) begin
			state     <= st_idle;
			cnt       <= '0;
			step_pend <= 1'b0;
			load_pend <= 1'b0;
			read_pend <= 1'b0;
			gen_done  <= 1'b0;
			gen_count <= '0;
		end else begin
			// New pulse replaces a pending one of the same kind
			step_pend <= (step || step_pend) && !start;
			load_pend <= load || (load_pend && !issue_load);
			read_pend <= read_req || (read_pend && !issue_read);

			gen_done <= flip_done; // Count moves with the pulse
			if (flip_done) begin
				gen_count <= gen_count + life_pkg::gen_cnt_t'(1);
			end

			case (state)
				st_idle: begin
					if (start) begin
						state <= st_gen;
						cnt   <= '0;
					end
				end
				st_gen: begin
					if (flip_done) begin
						state <= st_idle; // Banks swapped, free for host
					end
					if (cnt != last_cnt) begin
						cnt <= cnt + cnt_t'(1); // Holds during drain end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Host request payloads
	always_ff @(posedge clk4) begin
		if (load) begin
			pend_load_row   <= load_row;
			pend_load_cells <= load_cells;
		end
		if (read_req) begin
			pend_read_row <= read_row;
		end
	end

	//////////////////////////////////////////////////
	// Row command stream
	//////////////////////////////////////////////////

	// Reads ROWS-1, 0 .. ROWS-1, 0 then nothing while draining
	always_comb begin
		cmd = '0;
		cmd.op = life_pkg::op_none;
		if (state == st_gen && cnt <= last_read) begin
			cmd.op      = life_pkg::op_gen_read;
			cmd.addr    = life_pkg::row_addr_t'(cnt - cnt_t'(1));   // Ring wrap
			cmd.emit    = (cnt >= cnt_t'(2));                        // Window full
			cmd.wb_addr = life_pkg::row_addr_t'(cnt - cnt_t'(2));   // Centre row
			cmd.last    = (cnt == last_read);
		end else if (issue_load) begin
			cmd.op    = life_pkg::op_load;
			cmd.addr  = pend_load_row;
			cmd.cells = pend_load_cells;
		end else if (issue_read) begin
			cmd.op   = life_pkg::op_host_read;
			cmd.addr = pend_read_row;
		end
	end

endmodule

// ==== hdl/row_store.sv ====
/* Row store
   Two banks of rows, active bank for reads and loads, other bank for writeback */
`timescale 1ns/100ps

`include "life_settings.svh"

module row_store (
	input  logic                clk4,
	input  logic                reset,
	input  life_pkg::seq_cmd_t  cmd,
	input  life_pkg::wb_t       wb,
	output life_pkg::fetch_t    fetch,
	output logic                read_valid,
	output life_pkg::row_t      read_cells,
	output logic                flip_done
);

	life_pkg::row_t bank_mem [2][`LIFE_ROWS];

	logic active; // Bank holding the current generation

	// Single write port
	logic                wr_en;
	logic                wr_bank;
	life_pkg::row_addr_t wr_addr;
	life_pkg::row_t      wr_cells;

	// Read side
	life_pkg::row_t      rd_cells;
	logic                fetch_valid;
	logic                fetch_emit;
	logic                fetch_last;
	life_pkg::row_addr_t fetch_wb_addr;

	// Writebacks and loads never overlap, loads only come when idle
	always_comb begin
		if (wb.valid) begin
			wr_en    = 1'b1;
			wr_bank  = !active; // Next generation
			wr_addr  = wb.addr;
			wr_cells = wb.cells;
		end else begin
			wr_en    = (cmd.op == life_pkg::op_load);
			wr_bank  = active;
			wr_addr  = cmd.addr;
			wr_cells = cmd.cells;
		end
	end

	assign flip_done = wb.valid && wb.last;

	// Memory and read data
	always_ff @(posedge clk4) begin
		if (wr_en) begin
			bank_mem[wr_bank][wr_addr] <= wr_cells;
		end
		rd_cells      <= bank_mem[active][cmd.addr]; // Gen and host reads share it
		fetch_wb_addr <= cmd.wb_addr;
	end

	always_ff @(posedge clk4) begin
		if (reset) begin
			active      <= 1'b0;
			fetch_valid <= 1'b0;
			fetch_emit  <= 1'b0;
			fetch_last  <= 1'b0;
			read_valid  <= 1'b0;
		end else begin
			active      <= active ^ flip_done; // Swap after last writeback
			fetch_valid <= (cmd.op == life_pkg::op_gen_read);
			fetch_emit  <= cmd.emit;
			fetch_last  <= cmd.last;
			read_valid  <= (cmd.op == life_pkg::op_host_read);
		end
	end

	always_comb begin
		fetch.valid   = fetch_valid;
		fetch.cells   = rd_cells;
		fetch.emit    = fetch_emit;
		fetch.wb_addr = fetch_wb_addr;
		fetch.last    = fetch_last;
	end

	assign read_cells = rd_cells;

endmodule

// ==== hdl/neighbor_window.sv ====
/* Neighbour window
   Three row shift register presenting above, centre and below rows */
`timescale 1ns/100ps

module neighbor_window (
	input  logic               clk4,
	input  logic               reset,
	input  life_pkg::fetch_t   fetch,
	output life_pkg::triple_t  triple
);

	// Oldest row on top
	life_pkg::row_t win_above;
	life_pkg::row_t win_centre;
	life_pkg::row_t win_below;

	logic                emit_q;
	logic                last_q;
	life_pkg::row_addr_t wb_addr_q;

	// Shift on every generation read
	always_ff @(posedge clk4) begin
		if (fetch.valid) begin
			win_above  <= win_centre;
			win_centre <= win_below;
			win_below  <= fetch.cells; // Newest row
		end
		wb_addr_q <= fetch.wb_addr;
	end

	always_ff @(posedge clk4) begin
		if (reset) begin
			emit_q <= 1'b0;
			last_q <= 1'b0;
		end else begin
			emit_q <= fetch.valid && fetch.emit; // First two reads only fill
			last_q <= fetch.valid && fetch.emit && fetch.last;
		end
	end

	always_comb begin
		triple.valid   = emit_q;
		triple.above   = win_above;
		triple.centre  = win_centre;
		triple.below   = win_below;
		triple.wb_addr = wb_addr_q;
		triple.last    = last_q;
	end

endmodule

// ==== hdl/cell_rule.sv ====
/* Cell rule stage
   Neighbour count and survival/birth rule over a full row, registered */
`timescale 1ns/100ps

`include "life_settings.svh"

module cell_rule (
	input  logic               clk4,
	input  logic               reset,
	input  life_pkg::triple_t  triple,
	output life_pkg::wb_t      wb
);

	// Dead cell padding on both edges, pad bit c+1 is cell c
	logic [`LIFE_WIDTH+1:0] pad_above;
	logic [`LIFE_WIDTH+1:0] pad_centre;
	logic [`LIFE_WIDTH+1:0] pad_below;

	logic [3:0]     nbr_cnt [`LIFE_WIDTH]; // 0 to 8 live neighbours
	life_pkg::row_t next_row;

	logic                wb_valid;
	logic                wb_last;
	life_pkg::row_addr_t wb_addr;
	life_pkg::row_t      wb_cells;

	assign pad_above  = {1'b0, triple.above, 1'b0};
	assign pad_centre = {1'b0, triple.centre, 1'b0};
	assign pad_below  = {1'b0, triple.below, 1'b0};

	//////////////////////////////////////////////////
	// Count and rule per column
	//////////////////////////////////////////////////

	always_comb begin
		for (int c = 0; c < `LIFE_WIDTH; c++) begin
			nbr_cnt[c] = 4'(pad_above[c]) + 4'(pad_above[c+1]) + 4'(pad_above[c+2])
				+ 4'(pad_centre[c]) + 4'(pad_centre[c+2]) // Skip the cell itself
				+ 4'(pad_below[c]) + 4'(pad_below[c+1]) + 4'(pad_below[c+2]);
			// Birth on 3, survival on 2 or 3
			next_row[c] = (nbr_cnt[c] == 4'd3) || (triple.centre[c] && nbr_cnt[c] == 4'd2);
		end
	end

	// Result register
	always_ff @(posedge clk4) begin
		wb_addr  <= triple.wb_addr;
		wb_cells <= next_row;
	end

	always_ff @(posedge clk4) begin
		if (reset) begin
			wb_valid <= 1'b0;
			wb_last  <= 1'b0;
		end else begin
			wb_valid <= triple.valid;
			wb_last  <= triple.valid && triple.last;
		end
	end

	always_comb begin
		wb.valid = wb_valid;
		wb.addr  = wb_addr;
		wb.cells = wb_cells;
		wb.last  = wb_last;
	end

endmodule

// ==== hdl/life_top.sv ====
/* Life engine top
   Sequencer, row store, neighbour window and rule stage in one pipeline */
`timescale 1ns/100ps

module life_top (
	input  logic                 clk4,
	input  logic                 reset,
	input  logic                 step,       // Single generation strobe
	input  logic                 run,        // Free running while high
	input  logic                 load,
	input  life_pkg::row_addr_t  load_row,
	input  life_pkg::row_t       load_cells,
	input  logic                 read_req,
	input  life_pkg::row_addr_t  read_row,
	output logic                 busy,
	output logic                 gen_done,
	output life_pkg::gen_cnt_t   gen_count,
	output logic                 read_valid,
	output life_pkg::row_t       read_cells
);

	//////////////////////////////////////////////////
	// Pipeline links
	//////////////////////////////////////////////////

	life_pkg::seq_cmd_t cmd;    // Row commands
	life_pkg::fetch_t   fetch;  // Generation read data
	life_pkg::triple_t  triple; // Three row window
	life_pkg::wb_t      wb;     // New rows
	logic               flip_done;

	gen_sequencer i_seq (
		.clk4       (clk4),
		.reset      (reset),
		.step       (step),
		.run        (run),
		.load       (load),
		.load_row   (load_row),
		.load_cells (load_cells),
		.read_req   (read_req),
		.read_row   (read_row),
		.flip_done  (flip_done),
		.cmd        (cmd),
		.busy       (busy),
		.gen_done   (gen_done),
		.gen_count  (gen_count)
	);

	// Bank memory, fetch one cycle after cmd
	row_store i_store (
		.clk4       (clk4),
		.reset      (reset),
		.cmd        (cmd),
		.wb         (wb),
		.fetch      (fetch),
		.read_valid (read_valid),
		.read_cells (read_cells),
		.flip_done  (flip_done)
	);

	neighbor_window i_window (
		.clk4   (clk4),
		.reset  (reset),
		.fetch  (fetch),
		.triple (triple)
	);

	// Result written back into the idle bank
	cell_rule i_rule (
		.clk4   (clk4),
		.reset  (reset),
		.triple (triple),
		.wb     (wb)
	);

endmodule

// ==== test/tb_life.sv ====
/* Life engine testbench
   Table driven stimulus checked against a board model of the standard rule */
`timescale 1ns/100ps

`include "life_settings.svh"

module tb_life;

	typedef enum logic [2:0] {k_load, k_step, k_run_n, k_read, k_clear} kind_t;

	// Stimulus entry, count is steps for k_step and held pulses for k_run_n
	typedef struct packed {
		kind_t               kind;
		life_pkg::row_addr_t row;
		life_pkg::row_t      cells;
		logic [7:0]          count;
	} entry_t;

	localparam int n_entries = 21;
	localparam entry_t stim [n_entries] = '{
		'{k_clear, 4'd0, 16'h0000, 8'd0},
		'{k_load, 4'd7, 16'h0070, 8'd0},  // Horizontal blinker mid board
		'{k_step, 4'd0, 16'h0000, 8'd3},
		'{k_clear, 4'd0, 16'h0000, 8'd0},
		'{k_load, 4'd14, 16'h0004, 8'd0}, // Glider heading down through row 0
		'{k_load, 4'd15, 16'h0008, 8'd0},
		'{k_load, 4'd0, 16'h000E, 8'd0},
		'{k_step, 4'd0, 16'h0000, 8'd5},
		'{k_clear, 4'd0, 16'h0000, 8'd0},
		'{k_load, 4'd4, 16'h8001, 8'd0},  // Cells on both edges
		'{k_load, 4'd5, 16'h8001, 8'd0},
		'{k_load, 4'd6, 16'hC001, 8'd0},
		'{k_step, 4'd0, 16'h0000, 8'd2},
		'{k_load, 4'd9, 16'h0180, 8'd0},  // R-pentomino for the run
		'{k_load, 4'd10, 16'h00C0, 8'd0},
		'{k_load, 4'd11, 16'h0080, 8'd0},
		'{k_run_n, 4'd10, 16'h0000, 8'd3}, // Host read of row 10 mid run
		'{k_load, 4'd3, 16'h0FF0, 8'd0},
		'{k_read, 4'd3, 16'h0000, 8'd0},
		'{k_step, 4'd0, 16'h0000, 8'd1},
		'{k_read, 4'd9, 16'h0000, 8'd0}
	};

	localparam int cycle_limit = n_entries * (`LIFE_ROWS + 20) * 4;

	logic clk4 = 1'b0;
	logic reset;
	logic step;
	logic run;
	logic load;
	life_pkg::row_addr_t load_row;
	life_pkg::row_t      load_cells;
	logic read_req;
	life_pkg::row_addr_t read_row;
	logic busy;
	logic gen_done;
	life_pkg::gen_cnt_t  gen_count;
	logic read_valid;
	life_pkg::row_t      read_cells;

	life_pkg::row_t board [`LIFE_ROWS]; // Model board
	int exp_gen = 0;    // Model generations
	int done_seen = 0;  // gen_done pulses on the DUT
	int cycles = 0;
	int seed = 9213;

	always #5 clk4 = ~clk4;

	life_top i_dut (
		.clk4(clk4), .reset(reset), .step(step), .run(run),
		.load(load), .load_row(load_row), .load_cells(load_cells),
		.read_req(read_req), .read_row(read_row),
		.busy(busy), .gen_done(gen_done), .gen_count(gen_count),
		.read_valid(read_valid), .read_cells(read_cells)
	);

	//////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////

	always @(negedge clk4) begin
		if (gen_done) done_seen <= done_seen + 1;
	end

	always @(posedge clk4) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout, the run did not finish within %0d cycles", cycle_limit);
			$display("Testbench failed");
			$fatal(1, "timeout");
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// One generation of the model, vertical ring, dead cells past the edges
	task automatic model_step();
		life_pkg::row_t nxt [`LIFE_ROWS];
		int n;
		int rr;
		int cc;
		for (int r = 0; r < `LIFE_ROWS; r++) begin
			for (int c = 0; c < `LIFE_WIDTH; c++) begin
				n = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						rr = (r + dr + `LIFE_ROWS) % `LIFE_ROWS;
						cc = c + dc;
						if ((dr != 0 || dc != 0) && cc >= 0 && cc < `LIFE_WIDTH && board[rr][cc])
							n++;
					end
				end
				nxt[r][c] = (n == 3) || (board[r][c] && n == 2);
			end
		end
		board = nxt;
		exp_gen++;
	endtask

	//////////////////////////////////////////////////
	// Host side actions
	//////////////////////////////////////////////////

	task automatic do_load(input life_pkg::row_addr_t r, input life_pkg::row_t c);
		@(posedge clk4);
		load       <= 1'b1;
		load_row   <= r;
		load_cells <= c;
		@(posedge clk4);
		load <= 1'b0;
		board[r] = c; // Queued ahead of any later request
	endtask

	task automatic read_back(input life_pkg::row_addr_t r, output life_pkg::row_t v);
		@(posedge clk4);
		read_req <= 1'b1;
		read_row <= r;
		@(posedge clk4);
		read_req <= 1'b0;
		do begin
			@(negedge clk4);
		end while (!read_valid);
		v = read_cells;
	endtask

	task automatic compare_board();
		life_pkg::row_t got;
		for (int r = 0; r < `LIFE_ROWS; r++) begin
			read_back(life_pkg::row_addr_t'(r), got);
			check($sformatf("read_cells row %0d", r), 32'(got), 32'(board[r]));
		end
		check("gen_count", 32'(gen_count), 32'(exp_gen));
		check("gen_done pulses", 32'(done_seen), 32'(exp_gen));
	endtask

	task automatic do_step();
		@(posedge clk4);
		step <= 1'b1;
		@(posedge clk4);
		step <= 1'b0;
		@(negedge clk4);
		check("busy", 32'(busy), 32'd1); // Up one cycle after step
		while (!gen_done) @(negedge clk4);
		model_step();
	endtask

	// Hold run for n pulses, read one row after the first pulse
	task automatic run_gens(input int n, input life_pkg::row_addr_t rrow);
		int  seen;
		bit  hold;
		bit  req;
		bit  got;
		seen = 0;
		hold = 1'b1;
		req  = 1'b0;
		got  = 1'b0;
		while (1) begin
			@(posedge clk4);
			run      <= hold;
			read_req <= req;
			read_row <= rrow;
			req = 1'b0;
			@(negedge clk4);
			if (gen_done) begin
				model_step();
				seen++;
				req = (seen == 1); // Lands while the next generation runs
			end
			if (read_valid) begin
				check("gen_count at read", 32'(gen_count), 32'(exp_gen));
				check("read_cells during run", 32'(read_cells), 32'(board[rrow]));
				got = 1'b1;
			end
			if (seen >= n) hold = 1'b0;
			if (seen >= n && got && !busy && !gen_done) break;
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		life_pkg::row_t cells;
		reset      = 1'b1;
		step       = 1'b0;
		run        = 1'b0;
		load       = 1'b0;
		load_row   = '0;
		load_cells = '0;
		read_req   = 1'b0;
		read_row   = '0;
		repeat (4) @(posedge clk4);
		reset <= 1'b0;
		@(negedge clk4);
		check("busy", 32'(busy), 32'd0);
		check("gen_done", 32'(gen_done), 32'd0);
		check("read_valid", 32'(read_valid), 32'd0);
		check("gen_count", 32'(gen_count), 32'd0);

		// Random board, read back untouched
		for (int r = 0; r < `LIFE_ROWS; r++) begin
			cells = life_pkg::row_t'($random(seed));
			do_load(life_pkg::row_addr_t'(r), cells);
		end
		compare_board();

		for (int i = 0; i < n_entries; i++) begin
			case (stim[i].kind)
				k_clear: begin
					for (int r = 0; r < `LIFE_ROWS; r++)
						do_load(life_pkg::row_addr_t'(r), '0);
				end
				k_load: do_load(stim[i].row, stim[i].cells);
				k_step: begin
					repeat (int'(stim[i].count)) begin
						do_step();
						compare_board(); // Row by row after every step
					end
				end
				k_run_n: begin
					run_gens(int'(stim[i].count), stim[i].row);
					compare_board();
				end
				default: begin
					read_back(stim[i].row, cells);
					check($sformatf("read_cells row %0d", stim[i].row), 32'(cells),
						32'(board[stim[i].row]));
				end
			endcase
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/life_pkg.sv
hdl/gen_sequencer.sv
hdl/row_store.sv
hdl/neighbor_window.sv
hdl/cell_rule.sv
hdl/life_top.sv
test/tb_life.sv

// ==== Makefile ====
# Verilator build and run for the life engine testbench

VERILATOR ?= verilator
TOP       ?= tb_life
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0

SOURCES := $(wildcard hdl/*.sv hdl/*.svh test/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# A failing check ends in $$fatal, which gives a nonzero exit status
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
